// File: Makefile
# Verilator flow for the BTB testbench

.PHONY: all run lint clean

all: run

obj_dir/Vtb_btb: btb.f btb_pkg.sv btb_index_front.sv btb_bank.sv btb_hit_select.sv \
		btb_top.sv tb_btb.sv
	verilator --binary --timing --top-module tb_btb -f btb.f -o Vtb_btb

# Pass only if the log holds the pass line
run: obj_dir/Vtb_btb
	./obj_dir/Vtb_btb | tee sim.log
	grep -q '^\*\* PASS \*\*$$' sim.log

lint:
	verilator --lint-only -Wall --top-module btb_top \
		btb_pkg.sv btb_index_front.sv btb_bank.sv btb_hit_select.sv btb_top.sv

clean:
	rm -rf obj_dir sim.log

// File: btb.f
btb_pkg.sv
btb_index_front.sv
btb_bank.sv
btb_hit_select.sv
btb_top.sv
tb_btb.sv

// File: btb_bank.sv
`timescale 1ns/1ns

module btb_bank (
    input  logic                   clk,
    input  logic                   rst_n,
    input  btb_pkg::btb_bank_req_t req_i,
    output btb_pkg::btb_entry_t    rd_entry_o
);

    import btb_pkg::*;

    // --------------------
    // Storage
    // --------------------

    // Tag, target and type per entry
    btb_wdata_t mem [BTB_DEPTH];

    // One valid bit per entry, kept apart so reset can clear it
    logic [BTB_DEPTH-1:0] valid_q;

    // Registered read port
    logic       rd_valid_q;
    btb_wdata_t rd_data_q;

    // --------------------
    // Valid bits
    // --------------------

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q    <= '0;
            rd_valid_q <= 1'b0;
        end else begin
            // Read before write, old bit seen on a same-index hit
            rd_valid_q <= valid_q[req_i.ridx];
            if (req_i.we) begin
                valid_q[req_i.widx] <= 1'b1;
            end
        end
    end

    // --------------------
    // Entry array
    // --------------------

    always_ff @(posedge clk) begin
        // Read-first, old contents on a collision
        rd_data_q <= mem[req_i.ridx];
        if (req_i.we) begin
            // Direct mapped, newest write wins
            mem[req_i.widx] <= req_i.wdata;
        end
    end

    // --------------------
    // Read output
    // --------------------

    assign rd_entry_o.valid   = rd_valid_q;
    assign rd_entry_o.tag     = rd_data_q.tag;
    assign rd_entry_o.bta     = rd_data_q.bta;
    assign rd_entry_o.br_type = rd_data_q.br_type;

endmodule

// File: btb_hit_select.sv
`timescale 1ns/1ns

module btb_hit_select (
    input  btb_pkg::btb_lookup_t prev_lookup_i,
    input  btb_pkg::btb_tag_t    prev_tag_i,
    input  btb_pkg::btb_entry_t  rd_entry_i [btb_pkg::BTB_BANKS],
    output btb_pkg::btb_resp_t   resp_o
);

    import btb_pkg::*;

    // --------------------
    // Fall-through
    // --------------------

    // Start of the next aligned pair, shared by both slots
    pc_w_t fall_thru;

    assign fall_thru = {prev_lookup_i.pc[31:3] + 29'd1, 1'b0};

    // --------------------
    // Per-slot compare
    // --------------------

    logic [BTB_BANKS-1:0] slot_hit;

    always_comb begin
        for (int s = 0; s < BTB_BANKS; s++) begin
            // Stored valid and matching folded tag
            slot_hit[s] = rd_entry_i[s].valid && (rd_entry_i[s].tag == prev_tag_i);
        end
    end

    // --------------------
    // Response
    // --------------------

    always_comb begin
        resp_o.valid = prev_lookup_i.valid;
        resp_o.pc    = prev_lookup_i.pc;
        for (int s = 0; s < BTB_BANKS; s++) begin
            resp_o.slot[s].hit = slot_hit[s];
            if (slot_hit[s]) begin
                // Stored branch
                resp_o.slot[s].bta     = rd_entry_i[s].bta;
                resp_o.slot[s].br_type = rd_entry_i[s].br_type;
            end else begin
                // Miss, sequential fetch
                resp_o.slot[s].bta     = fall_thru;
                resp_o.slot[s].br_type = PC_RELATIVE;
            end
        end
    end

endmodule

// File: btb_index_front.sv
`timescale 1ns/1ns

module btb_index_front (
    input  logic                   clk,
    input  logic                   rst_n,
    input  btb_pkg::btb_lookup_t   lookup_i,
    input  btb_pkg::btb_update_t   update_i,
    output btb_pkg::btb_bank_req_t bank_req_o [btb_pkg::BTB_BANKS],
    output btb_pkg::btb_lookup_t   prev_lookup_o,
    output btb_pkg::btb_tag_t      prev_tag_o
);

    import btb_pkg::*;

    // --------------------
    // Address split
    // --------------------

    btb_index_t rd_index;
    btb_index_t wr_index;
    btb_wdata_t wr_data;
    logic       wr_odd;

    // Same index field for lookup and update
    assign rd_index = lookup_i.pc[BTB_INDEX_W+2:3];
    assign wr_index = update_i.pc[BTB_INDEX_W+2:3];

    // Bit 2 picks even or odd bank
    assign wr_odd = update_i.pc[2];

    // Entry payload, tag folded here
    assign wr_data.tag     = btb_fold_tag(update_i.pc);
    assign wr_data.bta     = update_i.bta;
    assign wr_data.br_type = update_i.br_type;

    // --------------------
    // Write steering
    // --------------------

    always_comb begin
        for (int b = 0; b < BTB_BANKS; b++) begin
            // Only the bank matching the word slot is written
            bank_req_o[b].we    = update_i.valid && (int'(wr_odd) == b);
            bank_req_o[b].widx  = wr_index;
            bank_req_o[b].wdata = wr_data;
            // Both banks read the same pair
            bank_req_o[b].ridx  = rd_index;
        end
    end

    // --------------------
    // Lookup delay stage
    // --------------------

    logic  lookup_valid_q;
    pc_w_t lookup_pc_q;

    // Valid is control, cleared by reset
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            lookup_valid_q <= 1'b0;
        end else begin
            lookup_valid_q <= lookup_i.valid;
        end
    end

    // Address follows the bank read by one cycle
    always_ff @(posedge clk) begin
        lookup_pc_q <= lookup_i.pc;
    end

    assign prev_lookup_o.valid = lookup_valid_q;
    assign prev_lookup_o.pc    = lookup_pc_q;

    // Tag of the pair now leaving the banks
    assign prev_tag_o = btb_fold_tag(lookup_pc_q);

endmodule

// File: btb_pkg.sv
package btb_pkg;

    // --------------------
    // Sizing
    // --------------------

    // One bank per word slot of the fetch pair
    localparam int unsigned BTB_BANKS = 2;

    // Index taken from word-address bits 3 upward
    localparam int unsigned BTB_INDEX_W = 9;

    // Entries per bank
    localparam int unsigned BTB_DEPTH = 1 << BTB_INDEX_W;

    // Width of the folded tag
    localparam int unsigned BTB_TAG_W = 15;

    // --------------------
    // Basic types
    // --------------------

    // Word address, byte offset dropped
    typedef logic [31:2] pc_w_t;

    typedef logic [BTB_INDEX_W-1:0] btb_index_t;
    typedef logic [BTB_TAG_W-1:0]   btb_tag_t;

    typedef enum logic [1:0] {
        PC_RELATIVE = 2'd0,
        CALL        = 2'd1,
        RETURN      = 2'd2,
        INDIRECT    = 2'd3
    } br_type_e;

    // --------------------
    // Bundles
    // --------------------

    // Fetch-side lookup of one aligned pair
    typedef struct packed {
        logic  valid;
        pc_w_t pc;
    } btb_lookup_t;

    // Execute-side update of one entry
    typedef struct packed {
        logic     valid;
        pc_w_t    pc;
        pc_w_t    bta;
        br_type_e br_type;
    } btb_update_t;

    // Payload held in the entry array
    typedef struct packed {
        btb_tag_t tag;
        pc_w_t    bta;
        br_type_e br_type;
    } btb_wdata_t;

    // Entry as read out of a bank
    typedef struct packed {
        logic     valid;
        btb_tag_t tag;
        pc_w_t    bta;
        br_type_e br_type;
    } btb_entry_t;

    // Answer for one word slot
    typedef struct packed {
        logic     hit;
        pc_w_t    bta;
        br_type_e br_type;
    } btb_slot_t;

    // Slot 0 is the even word, slot 1 the odd word
    typedef struct packed {
        logic                        valid;
        pc_w_t                       pc;
        btb_slot_t [BTB_BANKS-1:0]   slot;
    } btb_resp_t;

    // Per-bank write and read request
    typedef struct packed {
        logic       we;
        btb_index_t widx;
        btb_wdata_t wdata;
        btb_index_t ridx;
    } btb_bank_req_t;

    // Upper bits folded onto the bits above the index base
    function automatic btb_tag_t btb_fold_tag(input pc_w_t pc);
        return pc[31:17] ^ pc[17:3];
    endfunction

endpackage

// File: btb_top.sv
`timescale 1ns/1ns

module btb_top (
    input  logic                 clk,
    input  logic                 rst_n,
    input  btb_pkg::btb_lookup_t lookup_i,
    input  btb_pkg::btb_update_t update_i,
    output btb_pkg::btb_resp_t   resp_o
);

    import btb_pkg::*;

    // --------------------
    // Internal wiring
    // --------------------

    // Front to banks
    btb_bank_req_t bank_req [BTB_BANKS];

    // Banks to hit select
    btb_entry_t rd_entry [BTB_BANKS];

    // Lookup delayed to line up with bank reads
    btb_lookup_t prev_lookup;
    btb_tag_t    prev_tag;

    // --------------------
    // Address front
    // --------------------

    btb_index_front u_front (
        .clk           (clk),
        .rst_n         (rst_n),
        .lookup_i      (lookup_i),
        .update_i      (update_i),
        .bank_req_o    (bank_req),
        .prev_lookup_o (prev_lookup),
        .prev_tag_o    (prev_tag)
    );

    // --------------------
    // Banks
    // --------------------

    // Bank 0 even word, bank 1 odd word
    for (genvar g = 0; g < BTB_BANKS; g++) begin : g_bank
        btb_bank u_bank (
            .clk        (clk),
            .rst_n      (rst_n),
            .req_i      (bank_req[g]),
            .rd_entry_o (rd_entry[g])
        );
    end

    // --------------------
    // Hit select
    // --------------------

    // Combinational, response in the cycle after the lookup
    btb_hit_select u_hit_select (
        .prev_lookup_i (prev_lookup),
        .prev_tag_i    (prev_tag),
        .rd_entry_i    (rd_entry),
        .resp_o        (resp_o)
    );

endmodule

// File: tb_btb.sv
`timescale 1ns/1ns

module tb_btb;

    import btb_pkg::*;

    // --------------------
    // Run length
    // --------------------

    localparam int unsigned CLK_PERIOD      = 20;
    localparam int unsigned RESET_CYCLES    = 5;
    // Upper bound on directed tests plus drain
    localparam int unsigned DIRECTED_CYCLES = 40;
    localparam int unsigned RANDOM_CYCLES   = 2000;

    // --------------------
    // DUT and clock
    // --------------------

    logic        clk = 1'b0;
    logic        rst_n;
    btb_lookup_t lookup_i;
    btb_update_t update_i;
    btb_resp_t   resp_o;

    btb_top dut (
        .clk      (clk),
        .rst_n    (rst_n),
        .lookup_i (lookup_i),
        .update_i (update_i),
        .resp_o   (resp_o)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // --------------------
    // Reference model
    // --------------------

    // Mirror of both banks by slot and index
    btb_entry_t model_mem [BTB_BANKS][BTB_DEPTH];

    // One expected response per driven cycle
    btb_resp_t exp_q [$];
    string     name_q [$];

    // Tag bit i is address bit 17+i xor bit 3+i
    function automatic btb_tag_t expected_tag(input pc_w_t pc);
        btb_tag_t t;
        for (int i = 0; i < BTB_TAG_W; i++) begin
            t[i] = pc[17 + i] ^ pc[3 + i];
        end
        return t;
    endfunction

    function automatic btb_resp_t expected_resp(input pc_w_t pc);
        btb_resp_t  r;
        btb_entry_t e;
        pc_w_t      next_pair;
        // Start of the following aligned pair
        next_pair[31:3] = pc[31:3] + 29'd1;
        next_pair[2]    = 1'b0;
        r.valid = 1'b1;
        r.pc    = pc;
        for (int s = 0; s < BTB_BANKS; s++) begin
            // Index is word-address bits 11:3
            e = model_mem[s][pc[11:3]];
            if (e.valid && e.tag == expected_tag(pc)) begin
                r.slot[s].hit     = 1'b1;
                r.slot[s].bta     = e.bta;
                r.slot[s].br_type = e.br_type;
            end else begin
                r.slot[s].hit     = 1'b0;
                r.slot[s].bta     = next_pair;
                r.slot[s].br_type = PC_RELATIVE;
            end
        end
        return r;
    endfunction

    task automatic model_write(input btb_update_t up);
        btb_entry_t e;
        e.valid   = 1'b1;
        e.tag     = expected_tag(up.pc);
        e.bta     = up.bta;
        e.br_type = up.br_type;
        // Bit 2 picks the bank
        model_mem[up.pc[2]][up.pc[11:3]] = e;
    endtask

    // --------------------
    // Checks
    // --------------------

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("** FAIL **");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_resp(input string name, input btb_resp_t exp, input btb_resp_t act);
        if (act.valid !== exp.valid) begin
            stop_on_error($sformatf("error %s valid: expected %0b, actual %0b",
                                    name, exp.valid, act.valid));
        end else if (exp.valid && act.pc !== exp.pc) begin
            stop_on_error($sformatf("error %s pc: expected %h, actual %h",
                                    name, exp.pc, act.pc));
        end
    endtask

    task automatic check_slot(input string name, input int s,
                              input btb_slot_t exp, input btb_slot_t act);
        if (act !== exp) begin
            stop_on_error($sformatf("error %s slot %0d: expected %h, actual %h",
                                    name, s, exp, act));
        end
    endtask

    // --------------------
    // Stimulus helpers
    // --------------------

    function automatic btb_lookup_t make_lookup(input logic [31:0] addr);
        btb_lookup_t lk;
        lk.valid = 1'b1;
        lk.pc    = addr[31:2];
        return lk;
    endfunction

    function automatic btb_update_t make_update(input logic [31:0] addr,
                                                input logic [31:0] target,
                                                input br_type_e t);
        btb_update_t up;
        up.valid   = 1'b1;
        up.pc      = addr[31:2];
        up.bta     = target[31:2];
        up.br_type = t;
        return up;
    endfunction

    // Four tag groups over four indices where group 1 folds onto group 0
    function automatic logic [31:0] random_addr();
        logic [19:0] hi;
        logic [8:0]  idx;
        case ($urandom_range(0, 3))
            0: hi = 20'h00000;
            1: hi = 20'h40010;
            2: hi = 20'h00003;
            default: hi = 20'hfffff;
        endcase
        idx = 9'($urandom_range(0, 3));
        return {hi, idx, 1'($urandom_range(0, 1)), 2'b00};
    endfunction

    // One cycle of inputs with the expectation taken before the write
    task automatic drive_cycle(input string name, input btb_lookup_t lk,
                               input btb_update_t up);
        btb_resp_t none;
        none = '0;
        @(posedge clk);
        #2;
        lookup_i = lk;
        update_i = up;
        if (lk.valid) begin
            exp_q.push_back(expected_resp(lk.pc));
        end else begin
            exp_q.push_back(none);
        end
        name_q.push_back(name);
        // Read-first so the write shows from the next lookup on
        if (up.valid) begin
            model_write(up);
        end
    endtask

    // --------------------
    // Compare process
    // --------------------

    initial begin : compare_proc
        btb_resp_t exp;
        string     name;
        forever begin
            // Response comes from registers and settles just after the edge
            @(posedge clk);
            #1;
            if (exp_q.size() == 0) begin
                if (resp_o.valid !== 1'b0) begin
                    stop_on_error("response valid seen with no lookup pending");
                end
            end else begin
                exp  = exp_q.pop_front();
                name = name_q.pop_front();
                check_resp(name, exp, resp_o);
                if (exp.valid) begin
                    for (int s = 0; s < BTB_BANKS; s++) begin
                        check_slot(name, s, exp.slot[s], resp_o.slot[s]);
                    end
                end
            end
        end
    end

    // --------------------
    // Watchdog
    // --------------------

    initial begin : watchdog
        #((RESET_CYCLES + DIRECTED_CYCLES + RANDOM_CYCLES) * CLK_PERIOD * 2 + 1000);
        stop_on_error("watchdog expired before the tests finished");
    end

    // --------------------
    // Main sequence
    // --------------------

    initial begin : main_proc
        int unsigned seed_val;
        btb_lookup_t lk;
        btb_update_t up;
        rst_n    = 1'b0;
        // A lookup held valid through reset must give no response
        lookup_i = make_lookup(32'h0000_2000);
        update_i = '0;
        seed_val = $urandom(32'h1d73);
        for (int b = 0; b < BTB_BANKS; b++) begin
            for (int i = 0; i < BTB_DEPTH; i++) begin
                model_mem[b][i] = '0;
            end
        end
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        rst_n    = 1'b1;
        lookup_i = '0;

        // Cold buffer including the wrap of the top pair
        $display("test reset_miss");
        drive_cycle("reset_miss", make_lookup(32'h0000_1000), '0);
        drive_cycle("reset_miss", make_lookup(32'h8000_0008), '0);
        drive_cycle("reset_miss", make_lookup(32'hffff_fff8), '0);
        drive_cycle("reset_miss", make_lookup(32'h0012_3454), '0);

        // Even word first and then the odd word of another pair
        $display("test slot_hit");
        drive_cycle("slot_hit", '0, make_update(32'h0000_2000, 32'h0000_3000, CALL));
        drive_cycle("slot_hit", make_lookup(32'h0000_2000), '0);
        drive_cycle("slot_hit", '0, make_update(32'h0000_2104, 32'h8000_0040, RETURN));
        drive_cycle("slot_hit", make_lookup(32'h0000_2100), '0);
        drive_cycle("slot_hit", make_lookup(32'h0000_2000), '0);

        // Same index with another tag and then bits 30 and 16 flipped for an equal fold
        $display("test tag_fold");
        drive_cycle("tag_fold", make_lookup(32'h0000_4000), '0);
        drive_cycle("tag_fold", make_lookup(32'h4001_2000), '0);

        // Overwrite and then a write and read of one index in one cycle
        $display("test overwrite");
        drive_cycle("overwrite", '0, make_update(32'h0000_2000, 32'h0000_5000, RETURN));
        drive_cycle("overwrite", make_lookup(32'h0000_2000), '0);
        drive_cycle("overwrite", make_lookup(32'h0000_2000),
                    make_update(32'h0000_2000, 32'h0000_6000, INDIRECT));
        drive_cycle("overwrite", make_lookup(32'h0000_2000), '0);

        // Back-to-back lookups broken by idle cycles
        $display("test stream");
        for (int i = 0; i < 12; i++) begin
            if (i % 4 == 3) begin
                drive_cycle("stream", '0, '0);
            end else begin
                drive_cycle("stream", make_lookup(32'h0000_2000 + (32'(i) << 8)), '0);
            end
        end

        // Mixed lookups and updates on a few indices
        $display("test random");
        for (int i = 0; i < RANDOM_CYCLES; i++) begin
            lk = '0;
            up = '0;
            if ($urandom_range(0, 9) < 8) begin
                lk = make_lookup(random_addr());
            end
            if ($urandom_range(0, 1) == 1) begin
                up = make_update(random_addr(), $urandom(),
                                 br_type_e'(2'($urandom_range(0, 3))));
            end
            drive_cycle("random", lk, up);
        end

        // Drain the last responses
        drive_cycle("drain", '0, '0);
        drive_cycle("drain", '0, '0);
        @(posedge clk);
        #3;
        if (exp_q.size() != 0) begin
            stop_on_error("responses still pending at the end of the run");
        end else begin
            $display("** PASS **");
            $finish;
        end
    end

endmodule
